// File: source/aluPkg.sv
// shared ALU types; aluWidth sets parameter defaults, and any Width must be a power of two >= 4
package aluPkg;

  // default operand and result width
  localparam int aluWidth = 8;

  // one operand or result word at the default width
  typedef logic [aluWidth-1:0] aluData_t;

  // opcode encoding as seen at the top level opcode port
  typedef enum logic [3:0] {
    opAdd      = 4'h0,
    opSub      = 4'h1,
    opIncA     = 4'h2,
    opIncB     = 4'h3,
    opDecA     = 4'h4,
    opDecB     = 4'h5,
    opCmp      = 4'h6,  // flags only while y holds
    opAnd      = 4'h7,
    opOr       = 4'h8,
    opXor      = 4'h9,
    opCplA     = 4'hA,
    opCplB     = 4'hB,
    opShl      = 4'hC,
    opShr      = 4'hD,
    opClr      = 4'hE,
    opClrFlags = 4'hF   // clears carry, overflow and zero
  } aluOp_t;

  // what the shared adder hands back on its sum output
  typedef enum logic [1:0] {
    modeSum = 2'd0,  // ripple sum
    modeAnd = 2'd1,  // generate terms
    modeOr  = 2'd2,  // generate or propagate
    modeXor = 2'd3   // propagate terms
  } adderMode_t;

endpackage

// File: source/aluCtrlIf.sv
// decoder to datapath strobes; no handshake, every signal is a one-cycle pulse or level
`timescale 1ns/1ns

interface aluCtrlIf;
  import aluPkg::*;

  logic   loadInputs;   // capture a and b
  logic   loadOutputs;  // register result and flags
  aluOp_t op;           // only meaningful with loadOutputs
  logic   clrFlags;     // opClrFlags strobe

  modport decoder (
    output loadInputs,
    output loadOutputs,
    output op,
    output clrFlags
  );

  modport datapath (
    input loadInputs,
    input loadOutputs,
    input op,
    input clrFlags
  );

endinterface

// File: source/aluAdder.sv
// ripple-carry adder that doubles as and/or/xor unit; carryOut and overflow only valid in modeSum
`timescale 1ns/1ns

module aluAdder #(
  parameter int Width = aluPkg::aluWidth
) (
  input  logic [Width-1:0]   x,
  input  logic [Width-1:0]   y,
  input  logic               carryIn,
  input  aluPkg::adderMode_t mode,
  output logic [Width-1:0]   sum,
  output logic               carryOut,
  output logic               overflow
);
  import aluPkg::*;

  logic [Width-1:0] prop;  // per-bit propagate
  logic [Width-1:0] gen;   // per-bit generate
  logic [Width:0]   chain;

  assign prop = x ^ y;
  assign gen  = x & y;

  // carry ripple from lsb up
  always_comb
  begin
    chain[0] = carryIn;
    for (int i = 0; i < Width; i++)
    begin
      chain[i+1] = gen[i] | (prop[i] & chain[i]);
    end
  end

  // logic functions come straight off the p/g terms
  always_comb
  begin
    case (mode)
      modeAnd: sum = gen;
      modeOr:  sum = gen | prop;
      modeXor: sum = prop;
      default: sum = prop ^ chain[Width-1:0];
    endcase
  end

  assign carryOut = chain[Width];

  // signed overflow when carry into msb differs from carry out
  assign overflow = chain[Width] ^ chain[Width-1];

endmodule

// File: source/aluShifter.sv
// combinational log barrel shifter; Width must be a power of two, shifts fill with zeros
`timescale 1ns/1ns

module aluShifter #(
  parameter int Width = aluPkg::aluWidth
) (
  input  logic [Width-1:0]         x,
  input  logic [$clog2(Width)-1:0] amount,
  input  logic                     right,      // 1 = shift toward lsb
  output logic [Width-1:0]         z,
  output logic                     shiftedOut  // last bit that fell off
);

  localparam int Stages = $clog2(Width);

  logic [Width-1:0] stageVal [0:Stages];
  logic             stageOut [0:Stages];

  assign stageVal[0] = x;
  assign stageOut[0] = 1'b0;  // zero amount shifts nothing out

  // stage k moves the word by 2**k when amount[k] is set
  for (genvar k = 0; k < Stages; k++)
  begin : gStage
    localparam int Dist = 1 << k;

    assign stageVal[k+1] = !amount[k] ? stageVal[k] :
                           right      ? stageVal[k] >> Dist :
                                        stageVal[k] << Dist;

    // the bit nearest the word leaves last in this stage
    assign stageOut[k+1] = !amount[k] ? stageOut[k] :
                           right      ? stageVal[k][Dist-1] :
                                        stageVal[k][Width-Dist];
  end

  assign z          = stageVal[Stages];
  assign shiftedOut = stageOut[Stages];

endmodule

// File: source/aluDecoder.sv
// opcode decoder; loadInputs follows start combinationally, result strobes come one cycle later
`timescale 1ns/1ns

module aluDecoder (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  aluPkg::aluOp_t opcode,
  aluCtrlIf.decoder      ctrl,
  output logic           done
);
  import aluPkg::*;

  aluOp_t issueOp;     // opcode waiting for the result edge
  logic   issueValid;  // operand stage holds an item
  logic   isClrFlags;

  // operands are captured on the same edge that samples start
  assign ctrl.loadInputs = start;

  // opcode register
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      issueOp <= opcode;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      issueValid <= 1'b0;
    end
    else
    begin
      issueValid <= start;
    end
  end

  assign isClrFlags = (issueOp == opClrFlags);

  // result stage strobes
  assign ctrl.op          = issueOp;
  assign ctrl.loadOutputs = issueValid && !isClrFlags;
  assign ctrl.clrFlags    = issueValid && isClrFlags;

  // done lines up with the registered result
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= issueValid;
    end
  end

  // the datapath must never see both result strobes in one cycle
  strobeExclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(ctrl.loadOutputs && ctrl.clrFlags)
  ) else $error("loadOutputs and clrFlags high together at %0t", $time);

endmodule

// File: source/aluDatapath.sv
// operand, result and flag registers; op is only looked at while loadOutputs is high
`timescale 1ns/1ns

module aluDatapath #(
  parameter int Width = aluPkg::aluWidth
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [Width-1:0] a,
  input  logic [Width-1:0] b,
  aluCtrlIf.datapath       ctrl,
  output logic [Width-1:0] y,
  output logic             carry,
  output logic             overflow,
  output logic             zero
);
  import aluPkg::*;

  localparam int ShiftBits = $clog2(Width);

  logic [Width-1:0] aReg;
  logic [Width-1:0] bReg;

  logic [Width-1:0] adderX;
  logic [Width-1:0] adderY;
  logic             carryIn;
  adderMode_t       mode;
  logic [Width-1:0] adderSum;
  logic             adderCarry;
  logic             adderOvf;

  logic [Width-1:0] shiftVal;
  logic             shiftCarry;
  logic             shiftRight;

  logic [Width-1:0] result;    // value that zero is judged on
  logic             newCarry;
  logic             writeY;    // low for opCmp
  logic             writeOvf;  // arithmetic ops only
  logic             isLogicOp;

  // operand steering into the shared adder
  always_comb
  begin
    adderX  = aReg;
    adderY  = bReg;
    carryIn = 1'b0;
    mode    = modeSum;
    case (ctrl.op)
      opSub, opCmp:
      begin
        adderY  = ~bReg;  // a + ~b + 1
        carryIn = 1'b1;
      end
      opIncA:
      begin
        adderY  = '0;
        carryIn = 1'b1;
      end
      opIncB:
      begin
        adderX  = bReg;
        adderY  = '0;
        carryIn = 1'b1;
      end
      opDecA: adderY = '1;  // add all ones
      opDecB:
      begin
        adderX = bReg;
        adderY = '1;
      end
      opAnd:  mode = modeAnd;
      opOr:   mode = modeOr;
      opXor:  mode = modeXor;
      opCplA:
      begin
        adderY = '1;  // xor with ones inverts
        mode   = modeXor;
      end
      opCplB:
      begin
        adderX = bReg;
        adderY = '1;
        mode   = modeXor;
      end
      default: ;
    endcase
  end

  aluAdder #(.Width(Width)) adder0 (
    .x        (adderX),
    .y        (adderY),
    .carryIn  (carryIn),
    .mode     (mode),
    .sum      (adderSum),
    .carryOut (adderCarry),
    .overflow (adderOvf)
  );

  assign shiftRight = (ctrl.op == opShr);

  aluShifter #(.Width(Width)) shifter0 (
    .x          (aReg),
    .amount     (bReg[ShiftBits-1:0]),  // low log2 bits of b
    .right      (shiftRight),
    .z          (shiftVal),
    .shiftedOut (shiftCarry)
  );

  // result select and flag rules
  always_comb
  begin
    result   = adderSum;
    newCarry = 1'b0;
    writeY   = 1'b1;
    writeOvf = 1'b0;
    case (ctrl.op)
      opAdd, opSub, opIncA, opIncB, opDecA, opDecB:
      begin
        newCarry = adderCarry;
        writeOvf = 1'b1;
      end
      opCmp:
      begin
        newCarry = adderCarry;
        writeOvf = 1'b1;
        writeY   = 1'b0;
      end
      opShl, opShr:
      begin
        result   = shiftVal;
        newCarry = shiftCarry;
      end
      opClr: result = '0;
      default: ;
    endcase
  end

  // operands are cleared by opClr unless a new item loads on the same edge
  always_ff @(posedge clk)
  begin
    if (ctrl.loadInputs)
    begin
      aReg <= a;
      bReg <= b;
    end
    else if (ctrl.loadOutputs && ctrl.op == opClr)
    begin
      aReg <= '0;
      bReg <= '0;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      y        <= '0;
      carry    <= 1'b0;
      overflow <= 1'b0;
      zero     <= 1'b1;
    end
    else if (ctrl.clrFlags)
    begin
      carry    <= 1'b0;
      overflow <= 1'b0;
      zero     <= 1'b0;
    end
    else if (ctrl.loadOutputs)
    begin
      if (writeY)
      begin
        y <= result;
      end
      if (writeOvf)
      begin
        overflow <= adderOvf;
      end
      carry <= newCarry;
      zero  <= (result == '0);
    end
  end

  assign isLogicOp = ctrl.op inside {opAnd, opOr, opXor, opCplA, opCplB};

  zeroAfterZero: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.loadOutputs && result == '0 |=> zero
  ) else $error("zero flag low after a zero result at %0t", $time);

  carryClearLogic: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.loadOutputs && isLogicOp |=> !carry
  ) else $error("carry set after a logic op at %0t", $time);

endmodule

// File: source/aluTop.sv
// ALU top level; result one edge after start with done in the same cycle, no back-pressure
`timescale 1ns/1ns

module aluTop #(
  parameter int Width = aluPkg::aluWidth  // power of two, 4 or more
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  aluPkg::aluOp_t   opcode,
  input  logic [Width-1:0] a,
  input  logic [Width-1:0] b,
  output logic [Width-1:0] y,
  output logic             carry,
  output logic             overflow,
  output logic             zero,
  output logic             done
);

  aluCtrlIf ctrl0 ();

  aluDecoder decoder0 (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .opcode (opcode),
    .ctrl   (ctrl0.decoder),
    .done   (done)
  );

  aluDatapath #(.Width(Width)) datapath0 (
    .clk      (clk),
    .reset    (reset),
    .a        (a),
    .b        (b),
    .ctrl     (ctrl0.datapath),
    .y        (y),
    .carry    (carry),
    .overflow (overflow),
    .zero     (zero)
  );

endmodule

// File: test/aluChecker.sv
// reference model at the package default width; expects results in start order, no back-pressure
`timescale 1ns/1ns

module aluChecker (
  input logic             clk,
  input logic             reset,
  input logic             start,
  input aluPkg::aluOp_t   opcode,
  input aluPkg::aluData_t a,
  input aluPkg::aluData_t b,
  input aluPkg::aluData_t y,
  input logic             carry,
  input logic             overflow,
  input logic             zero,
  input logic             done
);
  import aluPkg::*;

  localparam int ShiftBits = $clog2(aluWidth);

  typedef struct packed {
    aluData_t y;
    logic     carry;
    logic     overflow;
    logic     zero;
  } outcome_t;

  outcome_t pending [$];  // one entry per start still in flight
  outcome_t modelState;   // outputs once every pushed op has finished
  outcome_t head;         // oldest entry as of the last edge
  int       depth;
  logic     started;

  int mismatchErrors = 0;
  int otherErrors    = 0;

  // outputs after op, given the outputs before it
  function automatic outcome_t applyOp(input aluOp_t op, input aluData_t opA,
                                       input aluData_t opB, input outcome_t prev);
    outcome_t          next;
    aluData_t          addX;
    aluData_t          addY;
    logic              cin;
    logic              arith;
    logic [aluWidth:0] total;
    int                amt;
    next  = prev;
    addX  = opA;
    addY  = opB;
    cin   = 1'b0;
    arith = 1'b1;
    amt   = int'(opB[ShiftBits-1:0]);
    case (op)
      opAdd: addY = opB;
      opSub, opCmp:
      begin
        addY = ~opB;  // a plus inverted b plus one
        cin  = 1'b1;
      end
      opIncA: addY = aluData_t'(1);
      opIncB:
      begin
        addX = opB;
        addY = aluData_t'(1);
      end
      opDecA:
      begin
        addY = ~aluData_t'(1);
        cin  = 1'b1;
      end
      opDecB:
      begin
        addX = opB;
        addY = ~aluData_t'(1);
        cin  = 1'b1;
      end
      default: arith = 1'b0;
    endcase
    total = {1'b0, addX} + {1'b0, addY} + {{aluWidth{1'b0}}, cin};
    if (arith)
    begin
      next.carry    = total[aluWidth];
      next.overflow = (addX[aluWidth-1] == addY[aluWidth-1]) &&
                      (total[aluWidth-1] != addX[aluWidth-1]);
      next.zero     = (total[aluWidth-1:0] == '0);
      if (op != opCmp)
      begin
        next.y = total[aluWidth-1:0];
      end
    end
    else
    begin
      next.carry = 1'b0;
      case (op)
        opAnd:  next.y = opA & opB;
        opOr:   next.y = opA | opB;
        opXor:  next.y = opA ^ opB;
        opCplA: next.y = ~opA;
        opCplB: next.y = ~opB;
        opShl:
        begin
          next.y     = opA << amt;
          next.carry = (amt == 0) ? 1'b0 : opA[aluWidth-amt];
        end
        opShr:
        begin
          next.y     = opA >> amt;
          next.carry = (amt == 0) ? 1'b0 : opA[amt-1];
        end
        opClr: next.y = '0;
        default: next.overflow = 1'b0;  // clear flags, y holds
      endcase
      next.zero = (op == opClrFlags) ? 1'b0 : (next.y == '0);
    end
    return next;
  endfunction

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pending.delete();
      modelState = '{y: '0, carry: 1'b0, overflow: 1'b0, zero: 1'b1};
      head    <= modelState;
      depth   <= 0;
      started <= 1'b0;
    end
    else
    begin
      if (done && pending.size() != 0)
      begin
        void'(pending.pop_front());
      end
      if (start)
      begin
        modelState = applyOp(opcode, a, b, modelState);
        pending.push_back(modelState);
        started <= 1'b1;
      end
      if (pending.size() != 0)
      begin
        head <= pending[0];
      end
      depth <= pending.size();
    end
  end

  idleAfterReset: assert property (
    @(posedge clk) disable iff (reset)
    !started |-> (y == '0 && zero && !carry && !overflow && !done)
  ) else
  begin
    mismatchErrors++;
    $display("mismatch at %0t: outputs moved before the first start", $time);
  end

  doneTiming: assert property (
    @(posedge clk) disable iff (reset)
    done == $past(start, 2)
  ) else
  begin
    otherErrors++;
    $display("done did not come exactly one cycle after its start (time %0t)", $time);
  end

  doneExpected: assert property (
    @(posedge clk) disable iff (reset)
    done |-> depth != 0
  ) else
  begin
    otherErrors++;
    $display("done was seen with no result pending (time %0t)", $time);
  end

  resultMatch: assert property (
    @(posedge clk) disable iff (reset)
    done |-> ({y, carry, overflow, zero} == head)
  ) else
  begin
    mismatchErrors++;
    $display("mismatch at %0t: y/c/v/z %0h/%0b/%0b/%0b, expected %0h/%0b/%0b/%0b", $time,
             $sampled(y), $sampled(carry), $sampled(overflow), $sampled(zero),
             $sampled(head.y), $sampled(head.carry), $sampled(head.overflow),
             $sampled(head.zero));
  end

endmodule

// File: test/aluTb.sv
// drives aluTop at the package default width; stimulus is fixed by the LFSR seed
`timescale 1ns/1ns

module aluTb;
  import aluPkg::*;

  localparam int ClkPeriod   = 4;
  localparam int DirectedOps = 12;
  localparam int ArithOps    = 60;
  localparam int LogicOps    = 60;
  localparam int BurstOps    = 40;
  localparam int TotalOps    = DirectedOps + ArithOps + LogicOps + BurstOps;

  logic        clk;
  logic        reset;
  logic        start;
  aluOp_t      opcode;
  aluData_t    a;
  aluData_t    b;
  aluData_t    y;
  logic        carry;
  logic        overflow;
  logic        zero;
  logic        done;
  logic [15:0] lfsrState;

  always #(ClkPeriod / 2) clk = ~clk;

  aluTop #(.Width(aluWidth)) dut0 (
    .clk(clk), .reset(reset), .start(start), .opcode(opcode), .a(a), .b(b),
    .y(y), .carry(carry), .overflow(overflow), .zero(zero), .done(done)
  );

  aluChecker checker0 (
    .clk(clk), .reset(reset), .start(start), .opcode(opcode), .a(a), .b(b),
    .y(y), .carry(carry), .overflow(overflow), .zero(zero), .done(done)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic takeBits(input int count, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[14:0], lfsrState[0]};
    end
  endtask

  task automatic driveOp(input aluOp_t op, input aluData_t opA, input aluData_t opB);
    @(posedge clk);
    #1;
    start  = 1'b1;
    opcode = op;
    a      = opA;
    b      = opB;
  endtask

  task automatic idleCycles(input int count);
    repeat (count)
    begin
      @(posedge clk);
      #1;
      start = 1'b0;
    end
  endtask

  // family 0 arithmetic and compare, 1 logic and shifts, 2 any opcode back to back
  task automatic randomOps(input int count, input int family);
    logic [15:0] bits;
    aluOp_t      op;
    aluData_t    opA;
    aluData_t    opB;
    for (int n = 0; n < count; n++)
    begin
      takeBits(8, bits);
      opA = bits[7:0];
      takeBits(8, bits);
      opB = bits[7:0];
      case (family)
        0:
        begin
          takeBits(3, bits);
          op = (bits[2:0] == 3'd7) ? opSub : aluOp_t'({1'b0, bits[2:0]});
        end
        1:
        begin
          takeBits(3, bits);
          op = (bits[2:0] == 3'd7) ? opShr : aluOp_t'(4'd7 + {1'b0, bits[2:0]});
        end
        default:
        begin
          takeBits(4, bits);
          op = aluOp_t'(bits[3:0]);
        end
      endcase
      driveOp(op, opA, opB);
      if (family != 2)
      begin
        takeBits(1, bits);  // random gap of zero or one cycle
        if (bits[0])
        begin
          idleCycles(1);
        end
      end
    end
    idleCycles(1);
  endtask

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    start     = 1'b0;
    opcode    = opAdd;
    a         = '0;
    b         = '0;
    lfsrState = 16'd37;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    idleCycles(3);  // reset values hold while idle
    driveOp(opAdd, 8'h80, 8'h80);  // carry, overflow and zero together
    driveOp(opClrFlags, 8'h12, 8'h34);
    idleCycles(1);
    driveOp(opAdd, 8'h7F, 8'h01);
    driveOp(opAnd, 8'hF0, 8'h3C);
    driveOp(opClr, 8'h55, 8'hAA);  // overflow must survive this
    driveOp(opSub, 8'h10, 8'h20);
    driveOp(opCmp, 8'h33, 8'h33);
    driveOp(opClrFlags, 8'h00, 8'h00);
    driveOp(opShl, 8'h81, 8'h01);
    driveOp(opShr, 8'h81, 8'h03);
    driveOp(opDecA, 8'h00, 8'h00);
    driveOp(opIncB, 8'h00, 8'hFF);
    idleCycles(1);
    randomOps(ArithOps, 0);
    randomOps(LogicOps, 1);
    randomOps(BurstOps, 2);
    wait (checker0.depth == 0);
    idleCycles(2);
    $display("errors: %0d mismatches, %0d other failures",
             checker0.mismatchErrors, checker0.otherErrors);
    if (checker0.mismatchErrors == 0 && checker0.otherErrors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog allows three cycles per op plus slack
  initial
  begin
    #((TotalOps * 3 + 50) * ClkPeriod);
    $display("timeout: results still pending after %0t", $time);
    $display("Something failed");
    $finish;
  end

endmodule

// File: src.f
source/aluPkg.sv
source/aluCtrlIf.sv
source/aluAdder.sv
source/aluShifter.sv
source/aluDecoder.sv
source/aluDatapath.sv
source/aluTop.sv
test/aluChecker.sv
test/aluTb.sv

// File: Makefile
TOP = aluTb
RTL = $(shell grep '^source/' src.f)

all: run

obj_dir/V$(TOP): src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --top-module aluTop $(RTL)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
